// ==== sim.f ====
+incdir+src
src/vdisp_pkg.sv
src/vdisp_if.sv
src/vdisp_decode.sv
src/vdisp_execute.sv
src/vdisp_result.sv
src/vdisp_top.sv
verif/vdisp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal
TOP       := vdisp_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/vdisp_tb.sv ====
//*********************************************************************
// Testbench for the vector dispatcher
//   Clock, reset and LFSR driven request and back-pressure stimulus
//   Reference model of vstart, vl and vtype with expected responses
//   In-order response compare and stall stability check
//   Request ready and response latency checks, timeout
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "vdisp_defs.svh"

module vdisp_tb;

  localparam int NUM_RANDOM = 300;
  // Ten cycles per request at worst for random and directed ones
  localparam int MAX_CYCLES = (NUM_RANDOM + 100) * 10;

  logic        clk_i;
  logic        reset_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [31:0] req_insn_i;
  logic [31:0] req_rs1_i;
  logic [31:0] req_rs2_i;
  logic [3:0]  req_trans_id_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic [31:0] resp_result_o;
  logic        resp_error_o;
  logic [3:0]  resp_trans_id_o;

  // Model copy of the architectural registers
  logic [31:0] model_vstart;
  logic [31:0] model_vl;
  logic [31:0] model_vtype;

  logic [31:0] lfsr;
  string       cur_name;
  // Entries are {trans_id, error, result}
  logic [36:0] exp_q[$];
  string       name_q[$];
  int          err_mismatch;
  int          err_protocol;
  int          cycles;
  logic        held;
  logic [36:0] held_val;
  logic        acc_prev;
  logic        bp_enable;
  logic [3:0]  next_id;

  vdisp_top dut0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_insn_i      (req_insn_i),
    .req_rs1_i       (req_rs1_i),
    .req_rs2_i       (req_rs2_i),
    .req_trans_id_i  (req_trans_id_i),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .resp_result_o   (resp_result_o),
    .resp_error_o    (resp_error_o),
    .resp_trans_id_o (resp_trans_id_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // SYSTEM encoding with rd = x1
  function automatic logic [31:0] csr_insn(logic [2:0] f3, logic [11:0] csr, logic [4:0] rs1);
    return {csr, rs1, f3, 5'd1, 7'h73};
  endfunction

  function automatic logic [31:0] vsetvli_insn(logic [10:0] zimm, logic [4:0] rs1,
                                                logic [4:0] rd);
    return {1'b0, zimm, rs1, 3'b111, rd, 7'h57};
  endfunction

  // rs2 index is x3 with its value carried by the request
  function automatic logic [31:0] vsetvl_insn(logic [4:0] rs1, logic [4:0] rd);
    return {7'b1000000, 5'd3, rs1, 3'b111, rd, 7'h57};
  endfunction

  // Returns {error, result} and steps the model state
  function automatic logic [32:0] ref_model(logic [31:0] insn, logic [31:0] rs1_val,
                                            logic [31:0] rs2_val);
    logic [2:0]  f3;
    logic        rs1_z;
    logic [31:0] req_vt;
    logic [31:0] src;
    logic [31:0] old;
    logic [31:0] vlmax;
    int          sew;
    int          lmul;
    f3 = insn[14:12];
    rs1_z = (insn[19:15] == 5'd0);
    if (insn[6:0] == 7'h57 && f3 == 3'b111 && (!insn[31] || insn[31:25] == 7'b1000000)) begin
      req_vt = insn[31] ? rs2_val : {21'd0, insn[30:20]};
      sew = int'(req_vt[5:3]);
      lmul = int'($signed(req_vt[2:0]));
      // LMUL must reach SEW/ELEN
      if (sew > 3 || lmul == -4 || $clog2(`VDISP_ELENB) + lmul < sew) begin
        model_vtype = 32'h8000_0000;
        model_vl = '0;
      end else begin
        vlmax = (lmul >= 0) ? ((`VDISP_VLENB >> sew) << lmul) : ((`VDISP_VLENB >> sew) >> -lmul);
        model_vtype = {24'd0, req_vt[7:0]};
        if (!rs1_z) begin
          model_vl = (rs1_val < vlmax) ? rs1_val : vlmax;
        end else if (insn[11:7] != 5'd0) begin
          model_vl = vlmax;
        end
      end
      return {1'b0, model_vl};
    end
    if (insn[6:0] == 7'h73 && f3 != 3'b000 && f3 != 3'b100) begin
      src = f3[2] ? {27'd0, insn[19:15]} : rs1_val;
      if (insn[31:20] == 12'h008) begin
        old = model_vstart;
        case (f3[1:0])
          2'b01:   model_vstart = src;
          2'b10:   model_vstart = old | src;
          default: model_vstart = old & ~src;
        endcase
        return {1'b0, old};
      end
      // Read-only CSRs through set or clear with no source
      if (f3[1:0] != 2'b01 && rs1_z) begin
        if (insn[31:20] == 12'hC20) return {1'b0, model_vl};
        if (insn[31:20] == 12'hC21) return {1'b0, model_vtype};
        if (insn[31:20] == 12'hC22) return {1'b0, 32'(`VDISP_VLENB)};
      end
    end
    return {1'b1, 32'd0};
  endfunction

  // Expected response recorded at acceptance
  always @(posedge clk_i) begin
    if (!reset_i && req_valid_i && req_ready_o) begin
      exp_q.push_back({req_trans_id_i, ref_model(req_insn_i, req_rs1_i, req_rs2_i)});
      name_q.push_back(cur_name);
    end
  end

  always @(posedge clk_i) begin : compare_resp
    logic [36:0] exp;
    string       name;
    if (!reset_i) begin
      if (held && (!resp_valid_o ||
                   {resp_trans_id_o, resp_error_o, resp_result_o} != held_val)) begin
        $display("Response with trans_id %0h changed while stalled", held_val[36:33]);
        err_protocol++;
      end
      held = resp_valid_o && !resp_ready_i;
      held_val = {resp_trans_id_o, resp_error_o, resp_result_o};
      if (resp_valid_o && resp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Response with trans_id %0h arrived with no request outstanding",
                   resp_trans_id_o);
          err_protocol++;
        end else begin
          exp = exp_q.pop_front();
          name = name_q.pop_front();
          if (resp_trans_id_o != exp[36:33]) begin
            $display("FAIL %s trans_id: expected %h actual %h", name, exp[36:33],
                     resp_trans_id_o);
            err_mismatch++;
          end
          if (resp_error_o != exp[32]) begin
            $display("FAIL %s error: expected %b actual %b", name, exp[32], resp_error_o);
            err_mismatch++;
          end
          if (resp_result_o != exp[31:0]) begin
            $display("FAIL %s result: expected %h actual %h", name, exp[31:0], resp_result_o);
            err_mismatch++;
          end
        end
      end
    end
  end

  // Ready tracks the response register and a response follows acceptance by one cycle
  always @(posedge clk_i) begin : check_flow
    logic ready_exp;
    ready_exp = !resp_valid_o || resp_ready_i;
    if (!reset_i) begin
      if (req_ready_o != ready_exp) begin
        $display("FAIL %s req_ready: expected %b actual %b", cur_name, ready_exp,
                 req_ready_o);
        err_mismatch++;
      end
      if (acc_prev && !resp_valid_o) begin
        $display("No response appeared in the cycle after a request was accepted");
        err_protocol++;
      end
    end
    acc_prev = !reset_i && req_valid_i && req_ready_o;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Drive one request and hold it until accepted
  task automatic issue_req(string name, logic [31:0] insn, logic [31:0] rs1, logic [31:0] rs2);
    cur_name       <= name;
    req_valid_i    <= 1'b1;
    req_insn_i     <= insn;
    req_rs1_i      <= rs1;
    req_rs2_i      <= rs2;
    req_trans_id_i <= next_id;
    next_id = next_id + 4'd1;
    do begin
      resp_ready_i <= bp_enable ? (rand_bits(2) != 0) : 1'b1;
      @(posedge clk_i);
    end while (!req_ready_o);
  endtask

  task automatic idle_cycle();
    req_valid_i  <= 1'b0;
    resp_ready_i <= bp_enable ? (rand_bits(2) != 0) : 1'b1;
    @(posedge clk_i);
  endtask

  task automatic run_directed();
    // Values after reset
    issue_req("reset_vtype", csr_insn(3'b010, 12'hC21, 5'd0), 32'd0, 32'd0);
    issue_req("reset_vl", csr_insn(3'b010, 12'hC20, 5'd0), 32'd0, 32'd0);
    issue_req("reset_vstart", csr_insn(3'b011, 12'h008, 5'd0), 32'd0, 32'd0);
    issue_req("reset_vlenb", csr_insn(3'b110, 12'hC22, 5'd0), 32'd0, 32'd0);
    // e32 m1 gives VLMAX 4
    issue_req("vsetvli_equal", vsetvli_insn(11'h010, 5'd2, 5'd1), 32'd4, 32'd0);
    issue_req("vsetvli_above", vsetvli_insn(11'h010, 5'd2, 5'd1), 32'd9, 32'd0);
    issue_req("vsetvli_below", vsetvli_insn(11'h010, 5'd2, 5'd1), 32'd3, 32'd0);
    // e8 m8 gives VLMAX 128
    issue_req("vsetvli_keep", vsetvli_insn(11'h003, 5'd0, 5'd0), 32'd77, 32'd0);
    issue_req("vsetvli_vlmax", vsetvli_insn(11'h003, 5'd0, 5'd1), 32'd77, 32'd0);
    issue_req("vsetvli_m8", vsetvli_insn(11'h003, 5'd2, 5'd1), 32'd200, 32'd0);
    issue_req("vsetvli_mf2", vsetvli_insn(11'h007, 5'd2, 5'd1), 32'd100, 32'd0);
    // Reserved SEW, reserved LMUL, LMUL below SEW/ELEN
    issue_req("illegal_sew", vsetvli_insn(11'h028, 5'd2, 5'd1), 32'd5, 32'd0);
    issue_req("illegal_vtype_rd", csr_insn(3'b010, 12'hC21, 5'd0), 32'd0, 32'd0);
    issue_req("vsetvli_legal", vsetvli_insn(11'h010, 5'd2, 5'd1), 32'd2, 32'd0);
    issue_req("illegal_lmul", vsetvli_insn(11'h004, 5'd2, 5'd1), 32'd5, 32'd0);
    issue_req("vsetvli_legal", vsetvli_insn(11'h010, 5'd2, 5'd1), 32'd2, 32'd0);
    issue_req("illegal_ratio", vsetvl_insn(5'd2, 5'd1), 32'd5, 32'h0000_001F);
    issue_req("illegal_vtype_rd", csr_insn(3'b010, 12'hC21, 5'd0), 32'd0, 32'd0);
    issue_req("illegal_vl_rd", csr_insn(3'b010, 12'hC20, 5'd0), 32'd0, 32'd0);
    // vstart write, set and clear
    issue_req("vstart_rw", csr_insn(3'b001, 12'h008, 5'd2), 32'h55, 32'd0);
    issue_req("vstart_rs", csr_insn(3'b010, 12'h008, 5'd2), 32'h0A, 32'd0);
    issue_req("vstart_rc", csr_insn(3'b011, 12'h008, 5'd2), 32'h05, 32'd0);
    issue_req("vstart_rwi", csr_insn(3'b101, 12'h008, 5'd7), 32'd0, 32'd0);
    issue_req("vstart_rsi", csr_insn(3'b110, 12'h008, 5'd8), 32'd0, 32'd0);
    issue_req("vstart_rci", csr_insn(3'b111, 12'h008, 5'd3), 32'd0, 32'd0);
    // Error cases over a known state
    issue_req("err_setup", vsetvli_insn(11'h008, 5'd2, 5'd1), 32'd5, 32'd0);
    issue_req("err_wr_vl", csr_insn(3'b001, 12'hC20, 5'd2), 32'd1, 32'd0);
    issue_req("err_wr_vtype", csr_insn(3'b001, 12'hC21, 5'd2), 32'd1, 32'd0);
    issue_req("err_wr_vlenb", csr_insn(3'b101, 12'hC22, 5'd0), 32'd0, 32'd0);
    issue_req("err_set_vl", csr_insn(3'b010, 12'hC20, 5'd2), 32'd1, 32'd0);
    issue_req("err_clr_vtype", csr_insn(3'b111, 12'hC21, 5'd2), 32'd0, 32'd0);
    issue_req("err_csr_addr", csr_insn(3'b010, 12'h300, 5'd0), 32'd0, 32'd0);
    issue_req("err_funct3_0", csr_insn(3'b000, 12'h000, 5'd0), 32'd0, 32'd0);
    issue_req("err_funct3_4", csr_insn(3'b100, 12'h008, 5'd0), 32'd0, 32'd0);
    issue_req("err_opcode", {25'h0ABCDE, 7'h33}, 32'd0, 32'd0);
    issue_req("err_opv_f3", {17'h00010, 3'b000, 5'd1, 7'h57}, 32'd0, 32'd0);
    issue_req("err_vsetvl_top", {7'b1100000, 5'd3, 5'd2, 3'b111, 5'd1, 7'h57}, 32'd1, 32'd8);
    issue_req("err_keep_vl", csr_insn(3'b010, 12'hC20, 5'd0), 32'd0, 32'd0);
    issue_req("err_keep_vtype", csr_insn(3'b010, 12'hC21, 5'd0), 32'd0, 32'd0);
    issue_req("err_keep_vstart", csr_insn(3'b010, 12'h008, 5'd0), 32'd0, 32'd0);
  endtask

  function automatic logic [11:0] pick_csr(logic [2:0] sel);
    case (sel)
      3'd1:    return 12'hC20;
      3'd2:    return 12'hC21;
      3'd3:    return 12'hC22;
      3'd4:    return 12'h300;
      3'd5:    return 12'hC23;
      default: return 12'h008;
    endcase
  endfunction

  task automatic run_random();
    logic [2:0]  cls;
    logic [4:0]  rs1_idx;
    logic [31:0] insn;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      if (rand_bits(3) == 0) begin
        idle_cycle();
      end
      cls = 3'(rand_bits(3));
      rs1_idx = (rand_bits(2) == 0) ? 5'd0 : 5'(rand_bits(5));
      case (cls)
        3'd0, 3'd1: insn = vsetvli_insn(11'(rand_bits(8)), rs1_idx, 5'(rand_bits(1)));
        3'd2:       insn = vsetvl_insn(rs1_idx, 5'(rand_bits(1)));
        3'd6:       insn = {25'(rand_bits(25)), 7'h33};
        default:    insn = csr_insn(3'(rand_bits(3)), pick_csr(3'(rand_bits(3))), rs1_idx);
      endcase
      issue_req("random", insn, 32'(rand_bits(8)), 32'(rand_bits(8)));
    end
  endtask

  initial begin
    lfsr           = 32'h8f2abaa1;
    err_mismatch   = 0;
    err_protocol   = 0;
    cycles         = 0;
    held           = 1'b0;
    held_val       = '0;
    acc_prev       = 1'b0;
    bp_enable      = 1'b0;
    next_id        = 4'd0;
    model_vstart   = '0;
    model_vl       = '0;
    model_vtype    = 32'h8000_0000;
    cur_name       = "idle";
    reset_i        = 1'b1;
    req_valid_i    = 1'b0;
    req_insn_i     = '0;
    req_rs1_i      = '0;
    req_rs2_i      = '0;
    req_trans_id_i = '0;
    resp_ready_i   = 1'b1;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    run_directed();
    bp_enable = 1'b1;
    run_random();
    req_valid_i  <= 1'b0;
    resp_ready_i <= 1'b1;
    do @(posedge clk_i); while (exp_q.size() != 0);
    @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d protocol", err_mismatch, err_protocol);
    if (err_mismatch == 0 && err_protocol == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/vdisp_top.sv ====
//*********************************************************************
// Vector dispatcher top level
//   Decode, execute and response stages
//   Plain valid/ready request and response ports
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "vdisp_defs.svh"

module vdisp_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Request from the scalar core
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic [31:0]            req_insn_i,
  input  logic [`VDISP_XLEN-1:0] req_rs1_i,
  input  logic [`VDISP_XLEN-1:0] req_rs2_i,
  input  logic [3:0]             req_trans_id_i,
  // Response to the scalar core
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output logic [`VDISP_XLEN-1:0] resp_result_o,
  output logic                   resp_error_o,
  output logic [3:0]             resp_trans_id_o
);

  dec_if dec_bus ();
  exe_if exe_bus ();

  // Request valid feeds the decoded valid
  vdisp_decode u_decode (
    .req_valid_i    (req_valid_i),
    .req_insn_i     (req_insn_i),
    .req_rs1_i      (req_rs1_i),
    .req_rs2_i      (req_rs2_i),
    .req_trans_id_i (req_trans_id_i),
    .dec_o          (dec_bus.dec_mp)
  );

  vdisp_execute u_execute (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .dec_i   (dec_bus.exe_mp),
    .exe_o   (exe_bus.exe_mp)
  );

  // Ready follows take of the response register
  vdisp_result u_result (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .exe_i           (exe_bus.res_mp),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .resp_result_o   (resp_result_o),
    .resp_error_o    (resp_error_o),
    .resp_trans_id_o (resp_trans_id_o)
  );

endmodule

`default_nettype wire

// ==== src/vdisp_result.sv ====
//*********************************************************************
// Response stage of the vector dispatcher
//   One-entry output register held under back-pressure
//   Take and request ready generation
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "vdisp_defs.svh"

module vdisp_result (
  input  logic                   clk_i,
  input  logic                   reset_i,
  exe_if.res_mp                  exe_i,
  output logic                   req_ready_o,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output logic [`VDISP_XLEN-1:0] resp_result_o,
  output logic                   resp_error_o,
  output logic [3:0]             resp_trans_id_o
);

  logic                   valid_q;
  logic [`VDISP_XLEN-1:0] result_q;
  logic                   error_q;
  logic [3:0]             trans_id_q;
  logic                   take;

  // Empty, or drained on this same edge
  assign take = !valid_q || resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= exe_i.valid;
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clk_i) begin
    if (exe_i.valid && take) begin
      result_q   <= exe_i.result;
      error_q    <= exe_i.error;
      trans_id_q <= exe_i.trans_id;
    end
  end

  assign exe_i.take = take;

  // Execute answers in the accepting cycle
  assign req_ready_o     = take;
  assign resp_valid_o    = valid_q;
  assign resp_result_o   = result_q;
  assign resp_error_o    = error_q;
  assign resp_trans_id_o = trans_id_q;

endmodule

`default_nettype wire

// ==== src/vdisp_execute.sv ====
//*********************************************************************
// Execute stage of the vector dispatcher
//   vstart, vl and vtype architectural registers
//   vsetvli / vsetvl legality check, VLMAX and stripmining
//   CSR read, write, set and clear with error reporting
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "vdisp_defs.svh"

module vdisp_execute (
  input  logic  clk_i,
  input  logic  reset_i,
  dec_if.exe_mp dec_i,
  exe_if.exe_mp exe_o
);

  localparam int unsigned ELEN_LOG2 = $clog2(`VDISP_ELENB);
  localparam logic [`VDISP_XLEN-1:0] VLENB_VAL = `VDISP_VLENB;
  // Value taken on reset and on any rejected vtype
  localparam vdisp_pkg::vtype_t VTYPE_ILLEGAL = '{
    vill:  1'b1,
    vma:   1'b0,
    vta:   1'b0,
    vsew:  vdisp_pkg::EW8,
    vlmul: 3'sd0
  };

  logic [`VDISP_XLEN-1:0] vstart_q, vstart_d;
  logic [`VDISP_XLEN-1:0] vl_q, vl_d;
  vdisp_pkg::vtype_t      vtype_q, vtype_d;

  vdisp_pkg::vtype_t      cfg_vtype;
  logic                   cfg_illegal;
  logic [2:0]             sew_log2;
  logic [2:0]             lmul_mag;
  logic [`VDISP_XLEN-1:0] vlmax;
  logic [`VDISP_XLEN-1:0] cfg_vl;
  logic [`VDISP_XLEN-1:0] csr_src;
  logic [`VDISP_XLEN-1:0] resp_result;
  logic                   resp_error;

  // Full CSR image, vill at the top
  function automatic logic [`VDISP_XLEN-1:0] vtype_to_xlen(vdisp_pkg::vtype_t vt);
    return {vt.vill, {(`VDISP_XLEN-9){1'b0}}, vt.vma, vt.vta, vt.vsew, vt.vlmul};
  endfunction

  // Requested vtype never carries vill
  function automatic vdisp_pkg::vtype_t vtype_from_xlen(logic [`VDISP_XLEN-1:0] x);
    return '{
      vill:  1'b0,
      vma:   x[7],
      vta:   x[6],
      vsew:  vdisp_pkg::vew_e'(x[5:3]),
      vlmul: x[2:0]
    };
  endfunction

  // zimm for vsetvli, rs2 for vsetvl
  assign cfg_vtype = (dec_i.op == vdisp_pkg::OP_VSETVLI) ?
                     vtype_from_xlen({{(`VDISP_XLEN-11){1'b0}}, dec_i.zimm}) :
                     vtype_from_xlen(dec_i.rs2_val);

  assign sew_log2 = cfg_vtype.vsew;

  // SEW above ELEN, reserved LMUL, or LMUL < SEW/ELEN
  assign cfg_illegal = (sew_log2 > 3'(ELEN_LOG2)) ||
                       (cfg_vtype.vlmul == 3'sb100) ||
                       ((int'(ELEN_LOG2) + int'(cfg_vtype.vlmul)) < int'(sew_log2));

  // Magnitude of log2 LMUL for fractional settings
  assign lmul_mag = cfg_vtype.vlmul[2] ? 3'(-cfg_vtype.vlmul) : cfg_vtype.vlmul;

  // VLMAX = LMUL * VLEN / SEW
  assign vlmax = cfg_vtype.vlmul[2] ? ((VLENB_VAL >> sew_log2) >> lmul_mag) :
                                      ((VLENB_VAL >> sew_log2) << lmul_mag);

  always_comb begin
    if (cfg_illegal) begin
      cfg_vl = '0;
    end else if (dec_i.rs1_zero && dec_i.rd_zero) begin
      // Keep current vl
      cfg_vl = vl_q;
    end else if (dec_i.rs1_zero) begin
      cfg_vl = vlmax;
    end else begin
      // Stripmining
      cfg_vl = (dec_i.rs1_val > vlmax) ? vlmax : dec_i.rs1_val;
    end
  end

  // Immediate forms take uimm zero-extended
  assign csr_src = (dec_i.op inside {vdisp_pkg::OP_CSRRWI, vdisp_pkg::OP_CSRRSI,
                                     vdisp_pkg::OP_CSRRCI}) ?
                   {{(`VDISP_XLEN-5){1'b0}}, dec_i.uimm} : dec_i.rs1_val;

  always_comb begin
    vstart_d    = vstart_q;
    vl_d        = vl_q;
    vtype_d     = vtype_q;
    resp_result = '0;
    resp_error  = 1'b0;
    case (dec_i.op)
      vdisp_pkg::OP_VSETVLI, vdisp_pkg::OP_VSETVL: begin
        vtype_d     = cfg_illegal ? VTYPE_ILLEGAL : cfg_vtype;
        vl_d        = cfg_vl;
        resp_result = cfg_vl;
      end
      // Only vstart is writable
      vdisp_pkg::OP_CSRRW, vdisp_pkg::OP_CSRRWI: begin
        if (dec_i.csr == vdisp_pkg::CSR_VSTART) begin
          resp_result = vstart_q;
          vstart_d    = csr_src;
        end else begin
          resp_error = 1'b1;
        end
      end
      vdisp_pkg::OP_CSRRS, vdisp_pkg::OP_CSRRSI,
      vdisp_pkg::OP_CSRRC, vdisp_pkg::OP_CSRRCI: begin
        case (dec_i.csr)
          vdisp_pkg::CSR_VSTART: begin
            resp_result = vstart_q;
            if (dec_i.op inside {vdisp_pkg::OP_CSRRS, vdisp_pkg::OP_CSRRSI}) begin
              vstart_d = vstart_q | csr_src;
            end else begin
              vstart_d = vstart_q & ~csr_src;
            end
          end
          // Read-only CSRs, legal only without a source
          vdisp_pkg::CSR_VL: begin
            resp_result = dec_i.rs1_zero ? vl_q : '0;
            resp_error  = !dec_i.rs1_zero;
          end
          vdisp_pkg::CSR_VTYPE: begin
            resp_result = dec_i.rs1_zero ? vtype_to_xlen(vtype_q) : '0;
            resp_error  = !dec_i.rs1_zero;
          end
          vdisp_pkg::CSR_VLENB: begin
            resp_result = dec_i.rs1_zero ? VLENB_VAL : '0;
            resp_error  = !dec_i.rs1_zero;
          end
          default: resp_error = 1'b1;
        endcase
      end
      default: resp_error = 1'b1;
    endcase
  end

  // Commit only when the response is accepted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= VTYPE_ILLEGAL;
    end else if (dec_i.valid && exe_o.take) begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
    end
  end

  assign exe_o.valid    = dec_i.valid;
  assign exe_o.result   = resp_result;
  assign exe_o.error    = resp_error;
  assign exe_o.trans_id = dec_i.trans_id;

endmodule

`default_nettype wire

// ==== src/vdisp_decode.sv ====
//*********************************************************************
// Instruction decoder of the vector dispatcher
//   Major opcode and funct3 match for OP-V config and SYSTEM CSR ops
//   Field extraction for CSR address, immediates and x0 flags
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "vdisp_defs.svh"

module vdisp_decode (
  input  logic                   req_valid_i,
  input  logic [31:0]            req_insn_i,
  input  logic [`VDISP_XLEN-1:0] req_rs1_i,
  input  logic [`VDISP_XLEN-1:0] req_rs2_i,
  input  logic [3:0]             req_trans_id_i,
  dec_if.dec_mp                  dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rd_idx;
  logic [4:0] rs1_idx;

  // Standard 32-bit encoding fields
  assign opcode  = req_insn_i[6:0];
  assign rd_idx  = req_insn_i[11:7];
  assign funct3  = req_insn_i[14:12];
  assign rs1_idx = req_insn_i[19:15];

  always_comb begin
    dec_o.op = vdisp_pkg::OP_ILLEGAL;
    case (opcode)
      // OP-V major opcode
      7'h57: begin
        // OPCFG funct3 holds the vset family
        if (funct3 == 3'b111) begin
          if (!req_insn_i[31]) begin
            dec_o.op = vdisp_pkg::OP_VSETVLI;
          end else if (req_insn_i[31:25] == 7'b1000000) begin
            dec_o.op = vdisp_pkg::OP_VSETVL;
          end
        end
      end
      // SYSTEM major opcode
      7'h73: begin
        case (funct3)
          3'b001:  dec_o.op = vdisp_pkg::OP_CSRRW;
          3'b010:  dec_o.op = vdisp_pkg::OP_CSRRS;
          3'b011:  dec_o.op = vdisp_pkg::OP_CSRRC;
          3'b101:  dec_o.op = vdisp_pkg::OP_CSRRWI;
          3'b110:  dec_o.op = vdisp_pkg::OP_CSRRSI;
          3'b111:  dec_o.op = vdisp_pkg::OP_CSRRCI;
          // ecall, ebreak and reserved funct3
          default: dec_o.op = vdisp_pkg::OP_ILLEGAL;
        endcase
      end
      default: dec_o.op = vdisp_pkg::OP_ILLEGAL;
    endcase
  end

  // Operand fields, meaningful only for the matching op
  assign dec_o.csr      = req_insn_i[31:20];
  assign dec_o.uimm     = rs1_idx;
  assign dec_o.zimm     = req_insn_i[30:20];
  assign dec_o.rs1_zero = (rs1_idx == 5'd0);
  assign dec_o.rd_zero  = (rd_idx == 5'd0);

  // Pass-along of request payload
  assign dec_o.valid    = req_valid_i;
  assign dec_o.rs1_val  = req_rs1_i;
  assign dec_o.rs2_val  = req_rs2_i;
  assign dec_o.trans_id = req_trans_id_i;

endmodule

`default_nettype wire

// ==== src/vdisp_if.sv ====
//*********************************************************************
// Stage interfaces of the vector dispatcher
//   dec_if : decoded instruction, decode to execute
//   exe_if : response and take, execute to result
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

`include "vdisp_defs.svh"

interface dec_if;
  logic                    valid;
  vdisp_pkg::vdisp_op_e    op;
  // Raw CSR field, may hold addresses outside csr_addr_e
  logic [11:0]             csr;
  logic [`VDISP_XLEN-1:0]  rs1_val;
  logic [`VDISP_XLEN-1:0]  rs2_val;
  logic [4:0]              uimm;
  logic [10:0]             zimm;
  // Register index fields equal to x0
  logic                    rs1_zero;
  logic                    rd_zero;
  logic [3:0]              trans_id;

  modport dec_mp (
    output valid, op, csr, rs1_val, rs2_val, uimm, zimm, rs1_zero, rd_zero, trans_id
  );

  modport exe_mp (
    input valid, op, csr, rs1_val, rs2_val, uimm, zimm, rs1_zero, rd_zero, trans_id
  );
endinterface

interface exe_if;
  logic                   valid;
  logic [`VDISP_XLEN-1:0] result;
  logic                   error;
  logic [3:0]             trans_id;
  // Response register can accept this cycle
  logic                   take;

  modport exe_mp (
    output valid, result, error, trans_id,
    input  take
  );

  modport res_mp (
    input  valid, result, error, trans_id,
    output take
  );
endinterface

`default_nettype wire

// ==== src/vdisp_pkg.sv ====
//*********************************************************************
// Vector dispatcher package
//   vdisp_op_e  : decoded operation
//   vew_e       : element width encoding
//   vtype_t     : vtype CSR fields
//   csr_addr_e  : vector CSR addresses
//*********************************************************************

`default_nettype none

package vdisp_pkg;

  // Operations understood by the dispatcher
  typedef enum logic [3:0] {
    OP_VSETVLI = 4'd0,
    OP_VSETVL  = 4'd1,
    // Register operand forms
    OP_CSRRW   = 4'd2,
    OP_CSRRS   = 4'd3,
    OP_CSRRC   = 4'd4,
    // 5-bit immediate forms
    OP_CSRRWI  = 4'd5,
    OP_CSRRSI  = 4'd6,
    OP_CSRRCI  = 4'd7,
    OP_ILLEGAL = 4'd15
  } vdisp_op_e;

  // SEW encoding, codes 4 to 7 reserved
  typedef enum logic [2:0] {
    EW8  = 3'd0,
    EW16 = 3'd1,
    EW32 = 3'd2,
    EW64 = 3'd3
  } vew_e;

  // Compact vtype, vlmul is signed log2 of LMUL
  typedef struct packed {
    logic              vill;
    logic              vma;
    logic              vta;
    vew_e              vsew;
    logic signed [2:0] vlmul;
  } vtype_t;

  typedef enum logic [11:0] {
    CSR_VSTART = 12'h008,
    CSR_VL     = 12'hC20,
    CSR_VTYPE  = 12'hC21,
    CSR_VLENB  = 12'hC22
  } csr_addr_e;

endpackage

`default_nettype wire

// ==== src/vdisp_defs.svh ====
//*********************************************************************
// Shared width and size defines for the vector dispatcher
//   VDISP_XLEN  : scalar operand and result width
//   VDISP_VLENB : bytes in one vector register
//   VDISP_ELENB : bytes in the widest element
//*********************************************************************

`ifndef VDISP_DEFS_SVH
`define VDISP_DEFS_SVH

// Scalar register width, fixed for RV32
`define VDISP_XLEN 32

// VLEN of 128 bits
`define VDISP_VLENB 16

// ELEN of 64 bits
`define VDISP_ELENB 8

`endif
